// ==== src/soc_macros.svh ====
// SoC address map and register offsets
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// External interrupt sources seen by the PLIC
`define SOC_NUM_IRQS        5

// RAM has a low window and everything from the high base upward
`define SOC_RAM_LO_END      32'h0000_2FFF
`define SOC_RAM_HI_BASE     32'h8000_0000

// CLINT window
`define SOC_CLINT_BASE      32'h0000_3000
`define SOC_CLINT_END       32'h0000_EFFF

// PLIC window
`define SOC_PLIC_BASE       32'h0000_F000
`define SOC_PLIC_END        32'h0000_FFFF

// CLINT offsets from SOC_CLINT_BASE
`define CLINT_MSIP          32'h0000_0000
`define CLINT_MTIMECMP_LO   32'h0000_4000
`define CLINT_MTIMECMP_HI   32'h0000_4004
`define CLINT_MTIME_LO      32'h0000_BFF8
`define CLINT_MTIME_HI      32'h0000_BFFC

// PLIC offsets from SOC_PLIC_BASE
`define PLIC_PENDING        32'h0000_0000
`define PLIC_ENABLE         32'h0000_0004
`define PLIC_CLAIM          32'h0000_0008

`endif

// ==== src/soc_pkg.sv ====
// SoC bus types
`default_nettype none

package soc_pkg;

    // ====================
    // Width types
    // ====================
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [63:0] mtime_t;
    // Zero means no source
    typedef logic [2:0]  irq_id_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // ====================
    // AXI4-Lite bundles
    // ====================
    // Master to slave
    typedef struct packed {
        addr_t aw_addr;
        logic  aw_valid;
        data_t w_data;
        strb_t w_strb;
        logic  w_valid;
        logic  b_ready;
        addr_t ar_addr;
        logic  ar_valid;
        logic  r_ready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        resp_t b_resp;
        logic  b_valid;
        logic  ar_ready;
        data_t r_data;
        resp_t r_resp;
        logic  r_valid;
    } axil_rsp_t;

    // Crossbar target and per-direction state
    typedef enum logic [1:0] {TGT_RAM, TGT_CLINT, TGT_PLIC, TGT_ERR} target_e;
    typedef enum logic [1:0] {ST_IDLE, ST_ROUTE, ST_RESP} xbar_state_e;

    // Byte-lane merge of write data into a register word
    function automatic data_t apply_strb(data_t old_val, data_t new_val, strb_t strb);
        data_t result;
        result = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== src/axil_xbar.sv ====
// AXI4-Lite crossbar
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module axil_xbar import soc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  axil_req_t s_req,
    output axil_rsp_t s_rsp,
    output axil_req_t ram_req,
    input  axil_rsp_t ram_rsp,
    output axil_req_t clint_req,
    input  axil_rsp_t clint_rsp,
    output axil_req_t plic_req,
    input  axil_rsp_t plic_rsp
);

    xbar_state_e wr_state_q, rd_state_q;
    target_e     wr_tgt_q, rd_tgt_q;
    // Index 3 is the local decode-error responder
    axil_req_t   tgt_req [4];
    axil_rsp_t   tgt_rsp [4];
    axil_rsp_t   err_rsp;
    logic        err_bvalid_q, err_rvalid_q;
    logic        wr_accept;

    function automatic target_e decode(addr_t addr);
        target_e tgt;
        if (addr <= `SOC_RAM_LO_END || addr >= `SOC_RAM_HI_BASE) begin
            tgt = TGT_RAM;
        end else if (addr >= `SOC_CLINT_BASE && addr <= `SOC_CLINT_END) begin
            tgt = TGT_CLINT;
        end else if (addr >= `SOC_PLIC_BASE && addr <= `SOC_PLIC_END) begin
            tgt = TGT_PLIC;
        end else begin
            tgt = TGT_ERR;
        end
        return tgt;
    endfunction

    // ====================
    // Request fan-out
    // ====================
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            tgt_req[i] = '0;
            // Write side only reaches the latched target
            if (wr_tgt_q == target_e'(i)) begin
                tgt_req[i].aw_addr  = s_req.aw_addr;
                tgt_req[i].w_data   = s_req.w_data;
                tgt_req[i].w_strb   = s_req.w_strb;
                tgt_req[i].aw_valid = s_req.aw_valid && (wr_state_q == ST_ROUTE);
                tgt_req[i].w_valid  = s_req.w_valid && (wr_state_q == ST_ROUTE);
                tgt_req[i].b_ready  = s_req.b_ready && (wr_state_q == ST_RESP);
            end
            if (rd_tgt_q == target_e'(i)) begin
                tgt_req[i].ar_addr  = s_req.ar_addr;
                tgt_req[i].ar_valid = s_req.ar_valid && (rd_state_q == ST_ROUTE);
                tgt_req[i].r_ready  = s_req.r_ready && (rd_state_q == ST_RESP);
            end
        end
    end

    assign ram_req   = tgt_req[TGT_RAM];
    assign clint_req = tgt_req[TGT_CLINT];
    assign plic_req  = tgt_req[TGT_PLIC];

    // Decode error responder, answers one cycle after acceptance
    always_comb begin
        err_rsp          = '0;
        err_rsp.aw_ready = tgt_req[TGT_ERR].aw_valid && tgt_req[TGT_ERR].w_valid
                           && !err_bvalid_q;
        err_rsp.w_ready  = err_rsp.aw_ready;
        err_rsp.b_resp   = RESP_DECERR;
        err_rsp.b_valid  = err_bvalid_q;
        err_rsp.ar_ready = tgt_req[TGT_ERR].ar_valid && !err_rvalid_q;
        err_rsp.r_resp   = RESP_DECERR;
        err_rsp.r_valid  = err_rvalid_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_bvalid_q <= 1'b0;
            err_rvalid_q <= 1'b0;
        end else begin
            if (err_rsp.aw_ready) begin
                err_bvalid_q <= 1'b1;
            end else if (tgt_req[TGT_ERR].b_ready) begin
                err_bvalid_q <= 1'b0;
            end
            if (err_rsp.ar_ready) begin
                err_rvalid_q <= 1'b1;
            end else if (tgt_req[TGT_ERR].r_ready) begin
                err_rvalid_q <= 1'b0;
            end
        end
    end

    // ====================
    // Response return
    // ====================
    always_comb begin
        tgt_rsp[TGT_RAM]   = ram_rsp;
        tgt_rsp[TGT_CLINT] = clint_rsp;
        tgt_rsp[TGT_PLIC]  = plic_rsp;
        tgt_rsp[TGT_ERR]   = err_rsp;
    end

    // aw and w are taken together in one edge
    assign wr_accept = (wr_state_q == ST_ROUTE) && tgt_rsp[wr_tgt_q].aw_ready
                       && tgt_rsp[wr_tgt_q].w_ready;

    always_comb begin
        s_rsp          = '0;
        s_rsp.aw_ready = wr_accept;
        s_rsp.w_ready  = wr_accept;
        s_rsp.ar_ready = (rd_state_q == ST_ROUTE) && tgt_rsp[rd_tgt_q].ar_ready;
        if (wr_state_q == ST_RESP) begin
            s_rsp.b_valid = tgt_rsp[wr_tgt_q].b_valid;
            s_rsp.b_resp  = tgt_rsp[wr_tgt_q].b_resp;
        end
        if (rd_state_q == ST_RESP) begin
            s_rsp.r_valid = tgt_rsp[rd_tgt_q].r_valid;
            s_rsp.r_data  = tgt_rsp[rd_tgt_q].r_data;
            s_rsp.r_resp  = tgt_rsp[rd_tgt_q].r_resp;
        end
    end

    // ====================
    // Direction FSMs
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state_q <= ST_IDLE;
            wr_tgt_q   <= TGT_ERR;
        end else begin
            case (wr_state_q)
                ST_IDLE: begin
                    // Latch the target once both aw and w are presented
                    if (s_req.aw_valid && s_req.w_valid) begin
                        wr_tgt_q   <= decode(s_req.aw_addr);
                        wr_state_q <= ST_ROUTE;
                    end
                end
                ST_ROUTE: if (wr_accept) wr_state_q <= ST_RESP;
                ST_RESP:  if (s_req.b_ready && s_rsp.b_valid) wr_state_q <= ST_IDLE;
                default:  wr_state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state_q <= ST_IDLE;
            rd_tgt_q   <= TGT_ERR;
        end else begin
            case (rd_state_q)
                ST_IDLE: begin
                    if (s_req.ar_valid) begin
                        rd_tgt_q   <= decode(s_req.ar_addr);
                        rd_state_q <= ST_ROUTE;
                    end
                end
                ST_ROUTE: if (s_req.ar_valid && s_rsp.ar_ready) rd_state_q <= ST_RESP;
                ST_RESP:  if (s_req.r_ready && s_rsp.r_valid) rd_state_q <= ST_IDLE;
                default:  rd_state_q <= ST_IDLE;
            endcase
        end
    end

    // At most one target sees a request at a time
    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_req.aw_valid, clint_req.aw_valid, plic_req.aw_valid})
        && $onehot0({ram_req.ar_valid, clint_req.ar_valid, plic_req.ar_valid}));

    // A passed-back response never coincides with one from an unlatched target
    a_resp_latched_b: assert property (@(posedge clk) disable iff (!rst_n)
        s_rsp.b_valid |-> (wr_tgt_q == TGT_RAM || !ram_rsp.b_valid)
                          && (wr_tgt_q == TGT_CLINT || !clint_rsp.b_valid)
                          && (wr_tgt_q == TGT_PLIC || !plic_rsp.b_valid));

    a_resp_latched_r: assert property (@(posedge clk) disable iff (!rst_n)
        s_rsp.r_valid |-> (rd_tgt_q == TGT_RAM || !ram_rsp.r_valid)
                          && (rd_tgt_q == TGT_CLINT || !clint_rsp.r_valid)
                          && (rd_tgt_q == TGT_PLIC || !plic_rsp.r_valid));

endmodule

`default_nettype wire

// ==== src/irq_clint.sv ====
// Core-local interruptor
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module irq_clint import soc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  axil_req_t s_req,
    output axil_rsp_t s_rsp,
    output logic      timer_irq,
    output logic      soft_irq
);

    mtime_t mtime_q;
    mtime_t mtimecmp_q;
    logic   msip_q;
    logic   b_valid_q, r_valid_q;
    data_t  r_data_q;
    data_t  rd_data;
    addr_t  wr_rel, rd_rel;
    logic   wr_fire, rd_fire;

    // Offsets relative to the CLINT window
    assign wr_rel = s_req.aw_addr - `SOC_CLINT_BASE;
    assign rd_rel = s_req.ar_addr - `SOC_CLINT_BASE;

    // Accept a write only with aw and w together and b channel free
    assign wr_fire = s_req.aw_valid && s_req.w_valid && !b_valid_q;
    assign rd_fire = s_req.ar_valid && !r_valid_q;

    always_comb begin
        s_rsp          = '0;
        s_rsp.aw_ready = wr_fire;
        s_rsp.w_ready  = wr_fire;
        s_rsp.b_resp   = RESP_OKAY;
        s_rsp.b_valid  = b_valid_q;
        s_rsp.ar_ready = rd_fire;
        s_rsp.r_data   = r_data_q;
        s_rsp.r_resp   = RESP_OKAY;
        s_rsp.r_valid  = r_valid_q;
    end

    // ====================
    // Timer registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
        end else begin
            // Free running, writes to mtime are dropped
            mtime_q <= mtime_q + 64'd1;
            if (wr_fire) begin
                case (wr_rel)
                    `CLINT_MSIP: if (s_req.w_strb[0]) msip_q <= s_req.w_data[0];
                    `CLINT_MTIMECMP_LO:
                        mtimecmp_q[31:0] <= apply_strb(mtimecmp_q[31:0], s_req.w_data,
                                                       s_req.w_strb);
                    `CLINT_MTIMECMP_HI:
                        mtimecmp_q[63:32] <= apply_strb(mtimecmp_q[63:32], s_req.w_data,
                                                        s_req.w_strb);
                    default: ;
                endcase
            end
        end
    end

    // Read mux, sampled at the ar handshake
    always_comb begin
        case (rd_rel)
            `CLINT_MSIP:        rd_data = {31'b0, msip_q};
            `CLINT_MTIMECMP_LO: rd_data = mtimecmp_q[31:0];
            `CLINT_MTIMECMP_HI: rd_data = mtimecmp_q[63:32];
            `CLINT_MTIME_LO:    rd_data = mtime_q[31:0];
            `CLINT_MTIME_HI:    rd_data = mtime_q[63:32];
            default:            rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_fire) r_data_q <= rd_data;
    end

    // Response valids, held until the master takes them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (wr_fire) b_valid_q <= 1'b1;
            else if (s_req.b_ready) b_valid_q <= 1'b0;
            if (rd_fire) r_valid_q <= 1'b1;
            else if (s_req.r_ready) r_valid_q <= 1'b0;
        end
    end

    assign timer_irq = (mtime_q >= mtimecmp_q);
    assign soft_irq  = msip_q;

    a_resp_after_hs: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(b_valid_q) |-> $past(wr_fire)) and ($rose(r_valid_q) |-> $past(rd_fire)));

endmodule

`default_nettype wire

// ==== src/irq_plic.sv ====
// Platform-level interrupt controller
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module irq_plic import soc_pkg::*; #(
    parameter int NUM_IRQS = `SOC_NUM_IRQS
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_IRQS-1:0] irq_in,
    input  axil_req_t           s_req,
    output axil_rsp_t           s_rsp,
    output logic                ext_irq
);

    logic [NUM_IRQS-1:0] pending_q, enable_q, in_service_q;
    logic [NUM_IRQS-1:0] active;
    logic [NUM_IRQS-1:0] claim_mask, complete_mask;
    irq_id_t             claim_id;
    data_t               enable_wr;
    data_t               rd_data, r_data_q;
    addr_t               wr_rel, rd_rel;
    logic                wr_fire, rd_fire;
    logic                b_valid_q, r_valid_q;

    assign wr_rel  = s_req.aw_addr - `SOC_PLIC_BASE;
    assign rd_rel  = s_req.ar_addr - `SOC_PLIC_BASE;
    assign wr_fire = s_req.aw_valid && s_req.w_valid && !b_valid_q;
    assign rd_fire = s_req.ar_valid && !r_valid_q;

    always_comb begin
        s_rsp          = '0;
        s_rsp.aw_ready = wr_fire;
        s_rsp.w_ready  = wr_fire;
        s_rsp.b_resp   = RESP_OKAY;
        s_rsp.b_valid  = b_valid_q;
        s_rsp.ar_ready = rd_fire;
        s_rsp.r_data   = r_data_q;
        s_rsp.r_resp   = RESP_OKAY;
        s_rsp.r_valid  = r_valid_q;
    end

    // ====================
    // Claim arbitration
    // ====================
    assign active = pending_q & enable_q;

    // Lowest numbered active source wins, id is index plus one
    always_comb begin
        claim_id = '0;
        for (int i = NUM_IRQS - 1; i >= 0; i--) begin
            if (active[i]) claim_id = irq_id_t'(i + 1);
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_IRQS; i++) begin
            claim_mask[i]    = rd_fire && (rd_rel == `PLIC_CLAIM)
                               && (claim_id == irq_id_t'(i + 1));
            complete_mask[i] = wr_fire && (wr_rel == `PLIC_CLAIM)
                               && (s_req.w_data == data_t'(i + 1));
        end
    end

    assign enable_wr = apply_strb(data_t'(enable_q), s_req.w_data, s_req.w_strb);

    // Gateway: level sources pend unless in service, claim clears wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q    <= '0;
            enable_q     <= '0;
            in_service_q <= '0;
        end else begin
            pending_q    <= (pending_q | (irq_in & ~in_service_q)) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
            if (wr_fire && wr_rel == `PLIC_ENABLE) enable_q <= enable_wr[NUM_IRQS-1:0];
        end
    end

    always_comb begin
        case (rd_rel)
            `PLIC_PENDING: rd_data = data_t'(pending_q);
            `PLIC_ENABLE:  rd_data = data_t'(enable_q);
            `PLIC_CLAIM:   rd_data = data_t'(claim_id);
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_fire) r_data_q <= rd_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (wr_fire) b_valid_q <= 1'b1;
            else if (s_req.b_ready) b_valid_q <= 1'b0;
            if (rd_fire) r_valid_q <= 1'b1;
            else if (s_req.r_ready) r_valid_q <= 1'b0;
        end
    end

    assign ext_irq = |active;

    // Returned claim id stays within the source count
    a_claim_range: assert property (@(posedge clk) disable iff (!rst_n)
        rd_fire && rd_rel == `PLIC_CLAIM |=> s_rsp.r_data <= data_t'(NUM_IRQS));

endmodule

`default_nettype wire

// ==== src/periph_harness.sv ====
// Peripheral harness top level
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module periph_harness import soc_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    // Master port from the core side
    input  axil_req_t                s_req,
    output axil_rsp_t                s_rsp,
    // External memory
    output axil_req_t                ram_req,
    input  axil_rsp_t                ram_rsp,
    // Interrupts
    input  logic [`SOC_NUM_IRQS-1:0] irq_in,
    output logic                     timer_irq,
    output logic                     soft_irq,
    output logic                     ext_irq
);

    axil_req_t clint_req, plic_req;
    axil_rsp_t clint_rsp, plic_rsp;

    // ====================
    // Address router
    // ====================
    axil_xbar axil_xbar_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_req     (s_req),
        .s_rsp     (s_rsp),
        .ram_req   (ram_req),
        .ram_rsp   (ram_rsp),
        .clint_req (clint_req),
        .clint_rsp (clint_rsp),
        .plic_req  (plic_req),
        .plic_rsp  (plic_rsp)
    );

    // Timer and software interrupts
    irq_clint irq_clint_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_req     (clint_req),
        .s_rsp     (clint_rsp),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    // External interrupts
    irq_plic #(
        .NUM_IRQS (`SOC_NUM_IRQS)
    ) irq_plic_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .irq_in  (irq_in),
        .s_req   (plic_req),
        .s_rsp   (plic_rsp),
        .ext_irq (ext_irq)
    );

endmodule

`default_nettype wire

// ==== tests/tb_periph_harness.sv ====
// Peripheral harness testbench
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module tb_periph_harness import soc_pkg::*; ();

    localparam int          TIMEOUT    = 200;
    localparam logic [63:0] OP_WRITE   = 64'("W");
    localparam logic [63:0] OP_READ    = 64'("R");
    localparam logic [63:0] OP_IRQ     = 64'("IRQ");
    localparam logic [63:0] OP_WAITIRQ = 64'("WAITIRQ");

    logic                     clk = 1'b0;
    logic                     rst_n;
    axil_req_t                s_req;
    axil_rsp_t                s_rsp;
    axil_req_t                ram_req;
    axil_rsp_t                ram_rsp = '0;
    logic [`SOC_NUM_IRQS-1:0] irq_in;
    logic                     timer_irq, soft_irq, ext_irq;

    // Bus state as seen at the last rising edge
    axil_req_t req_q = '0;
    axil_req_t ram_req_q = '0;
    axil_rsp_t rsp_q = '0;
    axil_rsp_t ram_rsp_q = '0;
    int        ram_valid_total = 0;

    // RAM model
    data_t       ram_mem [addr_t];
    addr_t       ram_last_awaddr, ram_last_araddr;
    strb_t       ram_last_strb;
    int          wr_phase = 0;
    int          rd_phase = 0;
    int          wr_cnt = 0;
    int          rd_cnt = 0;
    logic [31:0] lcg_state = 32'he5d0;

    int pass_cnt = 0;
    int fail_cnt = 0;

    periph_harness periph_harness_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_req     (s_req),
        .s_rsp     (s_rsp),
        .ram_req   (ram_req),
        .ram_rsp   (ram_rsp),
        .irq_in    (irq_in),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq),
        .ext_irq   (ext_irq)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        req_q     <= s_req;
        rsp_q     <= s_rsp;
        ram_req_q <= ram_req;
        ram_rsp_q <= ram_rsp;
        // Any request activity toward external memory
        if (ram_req.aw_valid || ram_req.w_valid || ram_req.ar_valid) begin
            ram_valid_total <= ram_valid_total + 1;
        end
    end

    // ====================
    // Helpers
    // ====================
    // LCG step, top two bits give a 0..3 cycle delay
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state >> 30);
    endfunction

    // Unwritten RAM words
    function automatic data_t ram_fill(addr_t a);
        return a ^ 32'h5a5a_a5a5;
    endfunction

    function automatic bit is_ram(addr_t a);
        return (a <= `SOC_RAM_LO_END) || (a >= `SOC_RAM_HI_BASE);
    endfunction

    // ====================
    // RAM responder
    // ====================
    always @(negedge clk) begin
        data_t word;
        addr_t key;
        case (wr_phase)
            0: if (ram_req_q.aw_valid && ram_req_q.w_valid) begin
                wr_cnt   = next_delay();
                wr_phase = 1;
            end
            1: if (wr_cnt > 0) begin
                wr_cnt--;
            end else begin
                ram_rsp.aw_ready = 1'b1;
                ram_rsp.w_ready  = 1'b1;
                wr_phase         = 2;
            end
            2: if (ram_req_q.aw_valid && ram_rsp_q.aw_ready) begin
                ram_rsp.aw_ready = 1'b0;
                ram_rsp.w_ready  = 1'b0;
                ram_last_awaddr  = ram_req_q.aw_addr;
                ram_last_strb    = ram_req_q.w_strb;
                key  = {ram_req_q.aw_addr[31:2], 2'b00};
                word = ram_mem.exists(key) ? ram_mem[key] : ram_fill(key);
                // Byte lanes
                for (int i = 0; i < 4; i++) begin
                    if (ram_req_q.w_strb[i]) word[i*8 +: 8] = ram_req_q.w_data[i*8 +: 8];
                end
                ram_mem[key] = word;
                wr_cnt       = next_delay();
                wr_phase     = 3;
            end
            3: if (wr_cnt > 0) begin
                wr_cnt--;
            end else begin
                ram_rsp.b_valid = 1'b1;
                ram_rsp.b_resp  = RESP_OKAY;
                wr_phase        = 4;
            end
            default: if (ram_rsp_q.b_valid && ram_req_q.b_ready) begin
                ram_rsp.b_valid = 1'b0;
                wr_phase        = 0;
            end
        endcase
        case (rd_phase)
            0: if (ram_req_q.ar_valid) begin
                rd_cnt   = next_delay();
                rd_phase = 1;
            end
            1: if (rd_cnt > 0) begin
                rd_cnt--;
            end else begin
                ram_rsp.ar_ready = 1'b1;
                rd_phase         = 2;
            end
            2: if (ram_req_q.ar_valid && ram_rsp_q.ar_ready) begin
                ram_rsp.ar_ready = 1'b0;
                ram_last_araddr  = ram_req_q.ar_addr;
                key = {ram_req_q.ar_addr[31:2], 2'b00};
                ram_rsp.r_data   = ram_mem.exists(key) ? ram_mem[key] : ram_fill(key);
                ram_rsp.r_resp   = RESP_OKAY;
                rd_cnt           = next_delay();
                rd_phase         = 3;
            end
            3: if (rd_cnt > 0) begin
                rd_cnt--;
            end else begin
                ram_rsp.r_valid = 1'b1;
                rd_phase        = 4;
            end
            default: if (ram_rsp_q.r_valid && ram_req_q.r_ready) begin
                ram_rsp.r_valid = 1'b0;
                rd_phase        = 0;
            end
        endcase
    end

    // ====================
    // Master tasks
    // ====================
    task automatic compare_value(input string name, input data_t expected,
                                 input data_t actual, inout bit ok);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
            ok = 0;
        end
    endtask

    task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                              output resp_t resp, inout bit ok);
        int t;
        bit hs;
        resp = '0;
        @(negedge clk);
        s_req.aw_addr  = addr;
        s_req.aw_valid = 1'b1;
        s_req.w_data   = data;
        s_req.w_strb   = strb;
        s_req.w_valid  = 1'b1;
        s_req.b_ready  = 1'b1;
        t  = 0;
        hs = 0;
        while (!hs && t < TIMEOUT) begin
            @(negedge clk);
            t++;
            hs = req_q.aw_valid && rsp_q.aw_ready && rsp_q.w_ready;
        end
        s_req.aw_valid = 1'b0;
        s_req.w_valid  = 1'b0;
        assert (hs) else begin
            $display("Timeout at %0t ns: write to %h was never accepted", $time, addr);
            ok = 0;
        end
        if (hs) begin
            t  = 0;
            hs = 0;
            while (!hs && t < TIMEOUT) begin
                @(negedge clk);
                t++;
                hs = req_q.b_ready && rsp_q.b_valid;
            end
            resp = rsp_q.b_resp;
            assert (hs) else begin
                $display("Timeout at %0t ns: no write response for %h", $time, addr);
                ok = 0;
            end
        end
        s_req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input addr_t addr, output data_t data, output resp_t resp,
                             inout bit ok);
        int t;
        bit hs;
        data = '0;
        resp = '0;
        @(negedge clk);
        s_req.ar_addr  = addr;
        s_req.ar_valid = 1'b1;
        s_req.r_ready  = 1'b1;
        t  = 0;
        hs = 0;
        while (!hs && t < TIMEOUT) begin
            @(negedge clk);
            t++;
            hs = req_q.ar_valid && rsp_q.ar_ready;
        end
        s_req.ar_valid = 1'b0;
        assert (hs) else begin
            $display("Timeout at %0t ns: read of %h was never accepted", $time, addr);
            ok = 0;
        end
        if (hs) begin
            t  = 0;
            hs = 0;
            while (!hs && t < TIMEOUT) begin
                @(negedge clk);
                t++;
                hs = req_q.r_ready && rsp_q.r_valid;
            end
            data = rsp_q.r_data;
            resp = rsp_q.r_resp;
            assert (hs) else begin
                $display("Timeout at %0t ns: no read data for %h", $time, addr);
                ok = 0;
            end
        end
        s_req.r_ready = 1'b0;
    endtask

    // Bit order {timer, soft, ext}
    task automatic wait_irq(input logic [2:0] mask, input logic [2:0] level, inout bit ok);
        int t;
        t = 0;
        while ((({timer_irq, soft_irq, ext_irq} & mask) != level) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        assert (({timer_irq, soft_irq, ext_irq} & mask) == level) else begin
            $display("Timeout at %0t ns: interrupt lines %b never matched %b under mask %b",
                     $time, {timer_irq, soft_irq, ext_irq}, level, mask);
            ok = 0;
        end
    endtask

    // ====================
    // Test runner
    // ====================
    initial begin
        int               fd;
        int               n;
        int               test_no;
        int               ram_valid_start;
        logic [8*160-1:0] line_buf;
        logic [63:0]      op_code;
        data_t            addr, data, expected, resp_exp;
        data_t            rdata, prev_mtime;
        resp_t            resp;
        bit               ok, have_mtime;

        s_req      = '0;
        irq_in     = '0;
        rst_n      = 1'b0;
        test_no    = 0;
        have_mtime = 0;
        prev_mtime = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("tests/periph_testdata.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the test data file");
            fail_cnt++;
        end
        line_buf = '0;
        while (fd != 0 && $fgets(line_buf, fd) != 0) begin
            n = $sscanf(line_buf, "%s %h %h %h %h", op_code, addr, data, expected, resp_exp);
            // Comment and blank lines never yield five fields
            if (n == 5) begin
                ok = 1;
                test_no++;
                ram_valid_start = ram_valid_total;
                if (op_code == OP_WRITE) begin
                    axil_write(addr, data, 4'hF, resp, ok);
                    compare_value("s_rsp.b_resp", resp_exp, data_t'(resp), ok);
                    if (is_ram(addr)) begin
                        compare_value("ram_req.aw_addr", addr, ram_last_awaddr, ok);
                        compare_value("ram_req.w_strb", 32'hF, data_t'(ram_last_strb), ok);
                    end else begin
                        compare_value("ram_req valid cycles", '0,
                                      data_t'(ram_valid_total - ram_valid_start), ok);
                    end
                end else if (op_code == OP_READ) begin
                    axil_read(addr, rdata, resp, ok);
                    compare_value("s_rsp.r_data", expected & data, rdata & data, ok);
                    compare_value("s_rsp.r_resp", resp_exp, data_t'(resp), ok);
                    if (is_ram(addr)) begin
                        compare_value("ram_req.ar_addr", addr, ram_last_araddr, ok);
                    end else begin
                        compare_value("ram_req valid cycles", '0,
                                      data_t'(ram_valid_total - ram_valid_start), ok);
                    end
                    // mtime low must keep counting up
                    if (addr == `SOC_CLINT_BASE + `CLINT_MTIME_LO) begin
                        if (have_mtime) begin
                            assert (rdata > prev_mtime) else begin
                                $display("mtime did not advance: %h then %h",
                                         prev_mtime, rdata);
                                ok = 0;
                            end
                        end
                        prev_mtime = rdata;
                        have_mtime = 1;
                    end
                end else if (op_code == OP_IRQ) begin
                    @(negedge clk);
                    irq_in = data[`SOC_NUM_IRQS-1:0];
                end else if (op_code == OP_WAITIRQ) begin
                    wait_irq(data[2:0], expected[2:0], ok);
                end else begin
                    $display("Unknown operation in test data line for test %0d", test_no);
                    ok = 0;
                end
                if (ok) pass_cnt++;
                else fail_cnt++;
                $display("test %0d addr %h data %h: %s", test_no, addr, data,
                         ok ? "passed" : "failed");
            end
            line_buf = '0;
        end
        if (fd != 0) $fclose(fd);

        $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/soc_pkg.sv
src/axil_xbar.sv
src/irq_clint.sv
src/irq_plic.sv
src/periph_harness.sv
tests/tb_periph_harness.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_periph_harness
FLIST     := flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== tests/periph_testdata.txt ====
# op  address  data_or_mask  expected  response
# R takes a compare mask in the data column, WAITIRQ a mask over {timer, soft, ext}
WAITIRQ 00000000 00000007 00000000 0
W 00000100 cafe0001 00000000 0
W 80000010 12345678 00000000 0
R 00000100 ffffffff cafe0001 0
R 80000010 ffffffff 12345678 0
W 00010000 deadbeef 00000000 3
R 00010000 ffffffff 00000000 3
W 00003000 00000001 00000000 0
WAITIRQ 00000000 00000002 00000002 0
R 00003000 ffffffff 00000001 0
W 00003000 00000000 00000000 0
WAITIRQ 00000000 00000002 00000000 0
R 0000eff8 00000000 00000000 0
R 0000eff8 00000000 00000000 0
W 00007004 00000000 00000000 0
W 00007000 00000040 00000000 0
WAITIRQ 00000000 00000004 00000004 0
W 00007004 ffffffff 00000000 0
WAITIRQ 00000000 00000004 00000000 0
IRQ 00000000 00000016 00000000 0
W 0000f004 00000006 00000000 0
WAITIRQ 00000000 00000001 00000001 0
R 0000f000 ffffffff 00000016 0
R 0000f008 ffffffff 00000002 0
IRQ 00000000 00000014 00000000 0
W 0000f008 00000002 00000000 0
R 0000f008 ffffffff 00000003 0
IRQ 00000000 00000010 00000000 0
W 0000f008 00000003 00000000 0
R 0000f008 ffffffff 00000000 0
WAITIRQ 00000000 00000001 00000000 0
